//--- Makefile
VERILATOR ?= verilator
TOP       ?= up_cpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/up_alu.sv
module up_alu (
   input  up_pkg::alu_op_e           op,
   input  up_pkg::a_sel_e            a_sel,
   input  up_pkg::b_sel_e            b_sel,
   input  logic [up_pkg::DATA_W-1:0] reg_a,
   input  logic [up_pkg::DATA_W-1:0] reg_b,
   input  logic [up_pkg::DATA_W-1:0] pc,
   input  logic [up_pkg::DATA_W-1:0] sp,
   output logic [up_pkg::DATA_W-1:0] result
);

   logic [up_pkg::DATA_W-1:0] opnd_a;
   logic [up_pkg::DATA_W-1:0] opnd_b;

   always_comb begin
      case (a_sel)
         up_pkg::A_PC: opnd_a = pc;
         up_pkg::A_SP: opnd_a = sp;
         default:      opnd_a = reg_a;
      endcase
   end

   assign opnd_b = (b_sel == up_pkg::B_ONE) ? up_pkg::DATA_W'(1) : reg_b;

   always_comb begin
      case (op)
         up_pkg::ALU_ADD:  result = opnd_a + opnd_b;
         up_pkg::ALU_SUB:  result = opnd_a - opnd_b;
         // low byte of the product only
         up_pkg::ALU_MUL:  result = opnd_a * opnd_b;
         up_pkg::ALU_DIV:  result = (opnd_b == '0) ? '1 : opnd_a / opnd_b;
         up_pkg::ALU_NAND: result = ~(opnd_a & opnd_b);
         up_pkg::ALU_NOR:  result = ~(opnd_a | opnd_b);
         up_pkg::ALU_XOR:  result = opnd_a ^ opnd_b;
         default:          result = opnd_b;
      endcase
   end

   // fourth a_sel code has no source
   always_comb begin
      assert (a_sel inside {up_pkg::A_REG, up_pkg::A_PC, up_pkg::A_SP})
         else $error("up_alu: unused a_sel encoding %0h", a_sel);
   end

endmodule

//--- hw/up_control.sv
module up_control (
   input  logic                    clk,
   input  logic                    nRst,
   input  logic [up_pkg::OP_W-1:0] ir,
   up_ctrl_if.ctrl                 ctrl,
   output logic                    mem_we,
   output logic                    halted
);

   up_pkg::state_e state;
   up_pkg::state_e state_next;
   up_pkg::op_e    op;

   assign op     = up_pkg::op_e'(ir);
   assign halted = (state == up_pkg::ST_HALT);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= up_pkg::ST_FETCH;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next        = state;
      mem_we            = 1'b0;
      ctrl.ir_we        = 1'b0;
      ctrl.pc_we        = 1'b0;
      ctrl.sp_we        = 1'b0;
      ctrl.rb_we        = 1'b0;
      // port A stays on r0, which is also the store data
      ctrl.rb_sel_out_a = 2'd0;
      ctrl.rb_sel_out_b = 2'd1;
      ctrl.rb_sel_in    = 2'd0;
      ctrl.wr_sel       = up_pkg::WR_ALU;
      ctrl.a_sel        = up_pkg::A_REG;
      ctrl.b_sel        = up_pkg::B_REG;
      ctrl.alu_op       = up_pkg::ALU_ADD;
      ctrl.addr_sel     = up_pkg::ADDR_PC;

      case (state)
         up_pkg::ST_FETCH: begin
            ctrl.ir_we = 1'b1;
            state_next = up_pkg::ST_EXEC;
         end
         up_pkg::ST_EXEC: begin
            state_next = up_pkg::ST_INCR;
            case (op)
               up_pkg::OP_LD: begin
                  ctrl.addr_sel  = up_pkg::ADDR_R2;
                  ctrl.wr_sel    = up_pkg::WR_MEM;
                  ctrl.rb_sel_in = 2'd1;
                  ctrl.rb_we     = 1'b1;
               end
               up_pkg::OP_ST: begin
                  ctrl.addr_sel = up_pkg::ADDR_R2;
                  mem_we        = 1'b1;
               end
               up_pkg::OP_MOV2, up_pkg::OP_MOV3: begin
                  // r0 through port B, passed unchanged
                  ctrl.rb_sel_out_b = 2'd0;
                  ctrl.alu_op       = up_pkg::ALU_PASSB;
                  ctrl.rb_sel_in    = (op == up_pkg::OP_MOV2) ? 2'd2 : 2'd3;
                  ctrl.rb_we        = 1'b1;
               end
               up_pkg::OP_PUSH: begin
                  ctrl.addr_sel = up_pkg::ADDR_SP;
                  mem_we        = 1'b1;
                  ctrl.a_sel    = up_pkg::A_SP;
                  ctrl.b_sel    = up_pkg::B_ONE;
                  ctrl.alu_op   = up_pkg::ALU_SUB;
                  ctrl.sp_we    = 1'b1;
               end
               up_pkg::OP_POP: begin
                  ctrl.a_sel  = up_pkg::A_SP;
                  ctrl.b_sel  = up_pkg::B_ONE;
                  ctrl.sp_we  = 1'b1;
                  state_next  = up_pkg::ST_POP_RD;
               end
               up_pkg::OP_JMP: begin
                  ctrl.pc_we = 1'b1;
                  state_next = up_pkg::ST_FETCH;
               end
               up_pkg::OP_HALT: begin
                  state_next = up_pkg::ST_HALT;
               end
               default: begin
                  ctrl.alu_op = up_pkg::alu_op_e'(ir[2:0]);
                  ctrl.rb_we  = 1'b1;
               end
            endcase
         end
         up_pkg::ST_POP_RD: begin
            ctrl.addr_sel = up_pkg::ADDR_SP;
            ctrl.wr_sel   = up_pkg::WR_MEM;
            ctrl.rb_we    = 1'b1;
            state_next    = up_pkg::ST_INCR;
         end
         up_pkg::ST_INCR: begin
            ctrl.a_sel = up_pkg::A_PC;
            ctrl.b_sel = up_pkg::B_ONE;
            ctrl.pc_we = 1'b1;
            state_next = up_pkg::ST_FETCH;
         end
         up_pkg::ST_HALT: state_next = up_pkg::ST_HALT;
         default:         state_next = up_pkg::ST_FETCH;
      endcase
   end

   // stores come from ST or PUSH in EXEC only
   assert property (@(posedge clk) disable iff (!nRst)
      mem_we |-> state == up_pkg::ST_EXEC && op inside {up_pkg::OP_ST, up_pkg::OP_PUSH})
      else $error("up_control: mem_we outside a store");

endmodule

//--- hw/up_cpu.sv
module up_cpu (
   input  logic                      clk,
   input  logic                      nRst,
   input  logic [up_pkg::DATA_W-1:0] mem_rdata,
   output logic [up_pkg::DATA_W-1:0] mem_addr,
   output logic [up_pkg::DATA_W-1:0] mem_wdata,
   output logic                      mem_we,
   output logic                      halted
);

   logic [up_pkg::OP_W-1:0] ir;

   // strobes and selects, control to datapath
   up_ctrl_if ctrl_bus ();

   up_control i_up_control (
      .clk    (clk),
      .nRst   (nRst),
      .ir     (ir),
      .ctrl   (ctrl_bus),
      .mem_we (mem_we),
      .halted (halted)
   );

   up_datapath i_up_datapath (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl_bus),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .ir        (ir)
   );

endmodule

//--- hw/up_ctrl_if.sv
interface up_ctrl_if;

   // write strobes
   logic                ir_we;
   logic                pc_we;
   logic                sp_we;
   logic                rb_we;

   // register block selects
   logic [1:0]          rb_sel_out_a;
   logic [1:0]          rb_sel_out_b;
   logic [1:0]          rb_sel_in;
   up_pkg::wr_sel_e     wr_sel;

   // alu and address selects
   up_pkg::a_sel_e      a_sel;
   up_pkg::b_sel_e      b_sel;
   up_pkg::alu_op_e     alu_op;
   up_pkg::addr_sel_e   addr_sel;

   modport ctrl (
      output ir_we, pc_we, sp_we, rb_we,
      output rb_sel_out_a, rb_sel_out_b, rb_sel_in, wr_sel,
      output a_sel, b_sel, alu_op, addr_sel
   );

   modport dp (
      input ir_we, pc_we, sp_we, rb_we,
      input rb_sel_out_a, rb_sel_out_b, rb_sel_in, wr_sel,
      input a_sel, b_sel, alu_op, addr_sel
   );

endinterface

//--- hw/up_datapath.sv
module up_datapath (
   input  logic                      clk,
   input  logic                      nRst,
   up_ctrl_if.dp                     ctrl,
   input  logic [up_pkg::DATA_W-1:0] mem_rdata,
   output logic [up_pkg::DATA_W-1:0] mem_addr,
   output logic [up_pkg::DATA_W-1:0] mem_wdata,
   output logic [up_pkg::OP_W-1:0]   ir
);

   logic [up_pkg::DATA_W-1:0] pc;
   logic [up_pkg::DATA_W-1:0] sp;
   logic [up_pkg::DATA_W-1:0] pc_next;
   logic [up_pkg::DATA_W-1:0] alu_result;
   logic [up_pkg::DATA_W-1:0] rb_wdata;
   logic [up_pkg::DATA_W-1:0] rdata_a;
   logic [up_pkg::DATA_W-1:0] rdata_b;
   logic [up_pkg::DATA_W-1:0] r2;
   logic [up_pkg::DATA_W-1:0] r3;
   up_pkg::instr_byte_u       ibyte;

   assign ibyte.data = mem_rdata;

   assign rb_wdata = (ctrl.wr_sel == up_pkg::WR_MEM) ? mem_rdata : alu_result;

   // jump target bypasses the alu
   assign pc_next = (up_pkg::op_e'(ir) == up_pkg::OP_JMP) ? r3 : alu_result;

   always_comb begin
      case (ctrl.addr_sel)
         up_pkg::ADDR_R2: mem_addr = r2;
         up_pkg::ADDR_SP: mem_addr = sp;
         // two instructions per byte
         default:         mem_addr = {1'b0, pc[up_pkg::DATA_W-1:1]};
      endcase
   end

   assign mem_wdata = rdata_a;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= up_pkg::PC_RST;
         sp <= up_pkg::SP_RST;
         ir <= '0;
      end else begin
         if (ctrl.pc_we) begin
            pc <= pc_next;
         end
         if (ctrl.sp_we) begin
            sp <= alu_result;
         end
         if (ctrl.ir_we) begin
            ir <= pc[0] ? ibyte.nib.hi : ibyte.nib.lo;
         end
      end
   end

   up_alu i_up_alu (
      .op     (ctrl.alu_op),
      .a_sel  (ctrl.a_sel),
      .b_sel  (ctrl.b_sel),
      .reg_a  (rdata_a),
      .reg_b  (rdata_b),
      .pc     (pc),
      .sp     (sp),
      .result (alu_result)
   );

   up_reg_block i_up_reg_block (
      .clk       (clk),
      .nRst      (nRst),
      .we        (ctrl.rb_we),
      .sel_in    (ctrl.rb_sel_in),
      .sel_out_a (ctrl.rb_sel_out_a),
      .sel_out_b (ctrl.rb_sel_out_b),
      .wdata     (rb_wdata),
      .rdata_a   (rdata_a),
      .rdata_b   (rdata_b),
      .r2        (r2),
      .r3        (r3)
   );

   // one alu result cannot feed both pointers
   assert property (@(posedge clk) disable iff (!nRst) !(ctrl.pc_we && ctrl.sp_we))
      else $error("up_datapath: pc_we and sp_we high together");

endmodule

//--- hw/up_pkg.sv
package up_pkg;

   localparam int DATA_W = 8;
   localparam int OP_W   = 4;

   // register block and pointer reset values
   localparam logic [DATA_W-1:0] REG_RST_0 = 8'h01;
   localparam logic [DATA_W-1:0] REG_RST_1 = 8'h02;
   localparam logic [DATA_W-1:0] REG_RST_2 = 8'h03;
   localparam logic [DATA_W-1:0] REG_RST_3 = 8'h04;
   localparam logic [DATA_W-1:0] PC_RST    = 8'h00;
   localparam logic [DATA_W-1:0] SP_RST    = 8'hFF;

   typedef enum logic [OP_W-1:0] {
      OP_ADD  = 4'h0, OP_SUB  = 4'h1, OP_MUL  = 4'h2, OP_DIV   = 4'h3,
      OP_NAND = 4'h4, OP_NOR  = 4'h5, OP_XOR  = 4'h6, OP_PASSB = 4'h7,
      OP_LD   = 4'h8, OP_ST   = 4'h9, OP_MOV2 = 4'hA, OP_MOV3  = 4'hB,
      OP_PUSH = 4'hC, OP_POP  = 4'hD, OP_JMP  = 4'hE, OP_HALT  = 4'hF
   } op_e;

   // low three opcode bits map straight onto these
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_NAND, ALU_NOR, ALU_XOR, ALU_PASSB
   } alu_op_e;

   typedef enum logic [1:0] {A_REG = 2'd0, A_PC = 2'd1, A_SP = 2'd2} a_sel_e;

   typedef enum logic [0:0] {B_REG = 1'b0, B_ONE = 1'b1} b_sel_e;

   typedef enum logic [1:0] {ADDR_PC = 2'd0, ADDR_R2 = 2'd1, ADDR_SP = 2'd2} addr_sel_e;

   typedef enum logic [0:0] {WR_ALU = 1'b0, WR_MEM = 1'b1} wr_sel_e;

   typedef enum logic [2:0] {
      ST_FETCH, ST_EXEC, ST_POP_RD, ST_INCR, ST_HALT
   } state_e;

   typedef struct packed {
      logic [OP_W-1:0] hi;
      logic [OP_W-1:0] lo;
   } nibbles_t;

   // one memory byte, seen as data or as two instructions
   typedef union packed {
      logic [DATA_W-1:0] data;
      nibbles_t          nib;
   } instr_byte_u;

endpackage

//--- hw/up_reg_block.sv
module up_reg_block (
   input  logic                      clk,
   input  logic                      nRst,
   input  logic                      we,
   input  logic [1:0]                sel_in,
   input  logic [1:0]                sel_out_a,
   input  logic [1:0]                sel_out_b,
   input  logic [up_pkg::DATA_W-1:0] wdata,
   output logic [up_pkg::DATA_W-1:0] rdata_a,
   output logic [up_pkg::DATA_W-1:0] rdata_b,
   output logic [up_pkg::DATA_W-1:0] r2,
   output logic [up_pkg::DATA_W-1:0] r3
);

   logic [up_pkg::DATA_W-1:0] regs [4];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs[0] <= up_pkg::REG_RST_0;
         regs[1] <= up_pkg::REG_RST_1;
         regs[2] <= up_pkg::REG_RST_2;
         regs[3] <= up_pkg::REG_RST_3;
      end else if (we) begin
         regs[sel_in] <= wdata;
      end
   end

   // two combinational read ports
   assign rdata_a = regs[sel_out_a];
   assign rdata_b = regs[sel_out_b];

   // r2 addresses LD/ST, r3 is the jump target
   assign r2 = regs[2];
   assign r3 = regs[3];

endmodule

//--- verif/up_cpu_tb.sv
module up_cpu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // whole run takes well under a thousand cycles
   localparam int MAX_CYCLES = 2000;
   localparam int RST_CYCLES = 16;

   logic                      clk;
   logic                      nRst;
   logic [up_pkg::DATA_W-1:0] mem_rdata;
   logic [up_pkg::DATA_W-1:0] mem_addr;
   logic [up_pkg::DATA_W-1:0] mem_wdata;
   logic                      mem_we;
   logic                      halted;

   logic [up_pkg::DATA_W-1:0] mem [256];
   up_pkg::op_e               prog_q [$];
   logic [up_pkg::DATA_W-1:0] preset_addr_q [$];
   logic [up_pkg::DATA_W-1:0] preset_data_q [$];
   logic [up_pkg::DATA_W-1:0] exp_addr_q [$];
   logic [up_pkg::DATA_W-1:0] exp_data_q [$];
   logic [up_pkg::DATA_W-1:0] wr_addr_q [$];
   logic [up_pkg::DATA_W-1:0] wr_data_q [$];
   int                        errors;
   int                        cycles;

   up_cpu i_up_cpu (
      .clk       (clk),
      .nRst      (nRst),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   // combinational read
   assign mem_rdata = mem[mem_addr];

   always #10 clk = ~clk;

   // clocked write, every store is logged
   always @(posedge clk) begin
      if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
         wr_addr_q.push_back(mem_addr);
         wr_data_q.push_back(mem_wdata);
         if (halted) begin
            $display("memory write to %h after the cpu halted", mem_addr);
            errors++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
         $display("errors: %0d", errors + 1);
         $display("Finished with errors");
         $finish;
      end
   end

   // reference results straight from the instruction table
   function automatic logic [up_pkg::DATA_W-1:0] alu_ref(input up_pkg::op_e op,
                                                         input logic [up_pkg::DATA_W-1:0] a,
                                                         input logic [up_pkg::DATA_W-1:0] b);
      logic [up_pkg::DATA_W-1:0] res;
      case (op)
         up_pkg::OP_ADD:  res = a + b;
         up_pkg::OP_SUB:  res = a - b;
         up_pkg::OP_MUL:  res = a * b;
         up_pkg::OP_DIV:  res = (b == 8'h00) ? 8'hFF : a / b;
         up_pkg::OP_NAND: res = ~(a & b);
         up_pkg::OP_NOR:  res = ~(a | b);
         up_pkg::OP_XOR:  res = a ^ b;
         default:         res = b;
      endcase
      return res;
   endfunction

   task automatic check_byte(input string name, input logic [up_pkg::DATA_W-1:0] got,
                             input logic [up_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input logic [up_pkg::DATA_W-1:0] got,
                             input logic [up_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Fail %s: address %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic add_write(input logic [up_pkg::DATA_W-1:0] addr,
                            input logic [up_pkg::DATA_W-1:0] data);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
   endtask

   task automatic preset(input logic [up_pkg::DATA_W-1:0] addr,
                         input logic [up_pkg::DATA_W-1:0] data);
      preset_addr_q.push_back(addr);
      preset_data_q.push_back(data);
   endtask

   task automatic load_memory();
      up_pkg::instr_byte_u ib;
      for (int a = 0; a < 256; a++) begin
         mem[a] <= 8'(a) ^ 8'h5A;
      end
      // two instructions per byte, low nibble first
      for (int i = 0; i < prog_q.size(); i += 2) begin
         ib.nib.lo = prog_q[i];
         ib.nib.hi = (i + 1 < prog_q.size()) ? prog_q[i + 1] : up_pkg::OP_HALT;
         mem[i / 2] <= ib.data;
      end
      for (int i = 0; i < preset_addr_q.size(); i++) begin
         mem[preset_addr_q[i]] <= preset_data_q[i];
      end
   endtask

   task automatic run_program();
      @(negedge clk);
      nRst = 1'b0;
      wr_addr_q.delete();
      wr_data_q.delete();
      load_memory();
      repeat (RST_CYCLES) @(negedge clk);
      nRst = 1'b1;
      while (!halted) @(negedge clk);
      repeat (4) @(negedge clk);
      if (!halted) begin
         $display("halted dropped after the program stopped");
         errors++;
      end
      if (wr_addr_q.size() != exp_addr_q.size()) begin
         $display("expected %0d memory writes but saw %0d", exp_addr_q.size(),
                  wr_addr_q.size());
         errors++;
      end else begin
         for (int i = 0; i < wr_addr_q.size(); i++) begin
            check_addr("mem_addr", wr_addr_q[i], exp_addr_q[i]);
            check_byte("mem_wdata", wr_data_q[i], exp_data_q[i]);
         end
      end
      exp_addr_q.delete();
      exp_data_q.delete();
      preset_addr_q.delete();
      preset_data_q.delete();
   endtask

   task automatic store_reset_values();
      prog_q = '{up_pkg::OP_PUSH, up_pkg::OP_PASSB, up_pkg::OP_PUSH, up_pkg::OP_ST,
                 up_pkg::OP_HALT};
      add_write(up_pkg::SP_RST, up_pkg::REG_RST_0);
      add_write(up_pkg::SP_RST - 8'd1, up_pkg::REG_RST_1);
      // store lands at the reset value of r2
      add_write(up_pkg::REG_RST_2, up_pkg::REG_RST_1);
      run_program();
      check_byte("mem[03]", mem[up_pkg::REG_RST_2], up_pkg::REG_RST_1);
   endtask

   task automatic sweep_alu_ops();
      up_pkg::op_e op;
      for (int k = 0; k < 8; k++) begin
         op = up_pkg::op_e'(4'(k));
         prog_q = '{op, up_pkg::OP_PUSH, up_pkg::OP_HALT};
         add_write(up_pkg::SP_RST, alu_ref(op, up_pkg::REG_RST_0, up_pkg::REG_RST_1));
         run_program();
         // byte 3 is HALT then PASSB, which reads back as the 7F operand
         prog_q = '{up_pkg::OP_LD, up_pkg::OP_PASSB, up_pkg::OP_MOV2, up_pkg::OP_LD, op,
                    up_pkg::OP_PUSH, up_pkg::OP_HALT, up_pkg::OP_PASSB};
         preset(8'h7F, 8'h00);
         add_write(up_pkg::SP_RST, alu_ref(op, 8'h7F, 8'h00));
         run_program();
      end
   endtask

   task automatic load_and_store();
      logic [up_pkg::DATA_W-1:0] base;
      logic [up_pkg::DATA_W-1:0] val;
      logic [up_pkg::DATA_W-1:0] dst;
      base = ~(up_pkg::REG_RST_0 | up_pkg::REG_RST_1);
      val  = 8'h3C;
      dst  = base ^ val;
      prog_q = '{up_pkg::OP_NOR, up_pkg::OP_MOV2, up_pkg::OP_LD, up_pkg::OP_XOR,
                 up_pkg::OP_MOV2, up_pkg::OP_PASSB, up_pkg::OP_ST, up_pkg::OP_HALT};
      preset(base, val);
      add_write(dst, val);
      run_program();
      check_byte($sformatf("mem[%h]", dst), mem[dst], val);
      check_byte($sformatf("mem[%h]", base), mem[base], val);
   endtask

   task automatic push_and_pop();
      logic [up_pkg::DATA_W-1:0] v0;
      logic [up_pkg::DATA_W-1:0] v1;
      logic [up_pkg::DATA_W-1:0] v2;
      v0 = ~(up_pkg::REG_RST_0 | up_pkg::REG_RST_1);
      v1 = v0 - up_pkg::REG_RST_1;
      v2 = v1 - up_pkg::REG_RST_1;
      prog_q = '{up_pkg::OP_NOR, up_pkg::OP_MOV2, up_pkg::OP_PUSH, up_pkg::OP_SUB,
                 up_pkg::OP_PUSH, up_pkg::OP_SUB, up_pkg::OP_PUSH, up_pkg::OP_POP,
                 up_pkg::OP_ST, up_pkg::OP_POP, up_pkg::OP_ST, up_pkg::OP_POP,
                 up_pkg::OP_ST, up_pkg::OP_HALT};
      add_write(up_pkg::SP_RST, v0);
      add_write(up_pkg::SP_RST - 8'd1, v1);
      add_write(up_pkg::SP_RST - 8'd2, v2);
      // pops come back newest first
      add_write(v0, v2);
      add_write(v0, v1);
      add_write(v0, v0);
      run_program();
      check_byte("mem[ff]", mem[8'hFF], v0);
      check_byte("mem[fe]", mem[8'hFE], v1);
      check_byte("mem[fd]", mem[8'hFD], v2);
   endtask

   task automatic jump_over_pushes();
      // r3 resets to 4 so the jump lands on the ADD; skipped pushes would store the marker
      prog_q = '{up_pkg::OP_JMP, up_pkg::OP_PUSH, up_pkg::OP_PUSH, up_pkg::OP_PUSH,
                 up_pkg::OP_ADD, up_pkg::OP_PUSH, up_pkg::OP_HALT};
      add_write(up_pkg::SP_RST, up_pkg::REG_RST_0 + up_pkg::REG_RST_1);
      run_program();
      check_byte("mem[ff]", mem[up_pkg::SP_RST], up_pkg::REG_RST_0 + up_pkg::REG_RST_1);
   endtask

   initial begin
      clk    = 1'b0;
      nRst   = 1'b0;
      errors = 0;
      cycles = 0;
      store_reset_values();
      sweep_alu_ops();
      load_and_store();
      push_and_pop();
      jump_over_pushes();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verilog.f
hw/up_pkg.sv
hw/up_ctrl_if.sv
hw/up_alu.sv
hw/up_reg_block.sv
hw/up_datapath.sv
hw/up_control.sv
hw/up_cpu.sv
verif/up_cpu_tb.sv
